// File: build.f
design/panel_pkg.sv
design/scan_pkg.sv
design/frame_buffer.sv
design/scan_controller.sv
design/led_panel_top.sv
tb/led_panel_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the LED panel testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module led_panel_tb -f build.f -o led_panel_sim > build.log 2>&1 \
	&& ./obj_dir/led_panel_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0

// File: tb/led_panel_tb.sv
/* LED panel scan engine testbench */

`timescale 1ns/100ps
`default_nettype none

module led_panel_tb;

	localparam int columns      = 8;
	localparam int rows         = 4;
	localparam int latch_cycles = 6;
	localparam int show_cycles  = 6;
	localparam int blank_cycles = 5;
	localparam int clk_period   = 10;

	localparam int row_cycles     = 4 * columns + latch_cycles + show_cycles + blank_cycles;
	localparam int frame_cycles   = row_cycles * rows;
	localparam int fill_cycles    = 2 * rows * columns;
	localparam int timeout_cycles = 20 * frame_cycles + fill_cycles;

	logic                 clk = 1'b0;
	logic                 rst;
	panel_pkg::fb_write_t fb_wr;
	logic                 fb_wr_stb;
	panel_pkg::row_t      row_addr;
	logic                 display_clk;
	logic                 latch;
	logic                 display_oe;
	panel_pkg::pixel_t    dout_a;
	panel_pkg::pixel_t    dout_b;

	panel_pkg::pixel_t ref_pix [2][rows][columns]; // mirror of every write, by half/row/col
	int                errors = 0;
	int                checks = 0;

	led_panel_top #(
		.columns      (columns),
		.rows         (rows),
		.latch_cycles (latch_cycles),
		.show_cycles  (show_cycles),
		.blank_cycles (blank_cycles)
	) led_panel_top_i (
		.clk         (clk),
		.rst         (rst),
		.fb_wr       (fb_wr),
		.fb_wr_stb   (fb_wr_stb),
		.row_addr    (row_addr),
		.display_clk (display_clk),
		.latch       (latch),
		.display_oe  (display_oe),
		.dout_a      (dout_a),
		.dout_b      (dout_b)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// first cycle of the next latch pulse, at a falling edge
	task automatic find_latch();
		@(negedge clk);
		while (latch)
			@(negedge clk);
		while (!latch)
			@(negedge clk);
	endtask

	// next shift pulse, sampled mid-cycle
	task automatic wait_shift(output panel_pkg::row_t r, output panel_pkg::pixel_t a,
			output panel_pkg::pixel_t b);
		@(negedge clk);
		while (!display_clk)
			@(negedge clk);
		r = row_addr;
		a = dout_a;
		b = dout_b;
	endtask

	// returns just after the last row's latch, next pulse is row 0 col 0
	task automatic sync_frame_start();
		find_latch();
		while (int'(row_addr) != rows - 1)
			find_latch();
		while (latch)
			@(negedge clk);
	endtask

	task automatic write_pixel(input int h, input int r, input int c, input panel_pkg::pixel_t p);
		@(negedge clk);
		fb_wr.half  = 1'(h);
		fb_wr.row   = panel_pkg::row_t'(r);
		fb_wr.col   = panel_pkg::col_t'(c);
		fb_wr.pixel = p;
		fb_wr_stb   = 1'b1;
		ref_pix[h][r][c] = p;
	endtask

	task automatic stop_writes();
		@(negedge clk);
		fb_wr_stb = 1'b0;
	endtask

	// one whole frame against the reference
	task automatic check_frame(input string name);
		panel_pkg::row_t   r;
		panel_pkg::pixel_t a;
		panel_pkg::pixel_t b;
		for (int i = 0; i < rows; i++) begin
			for (int k = 0; k < columns; k++) begin
				wait_shift(r, a, b);
				check_value($sformatf("%s row", name), i, int'(r));
				check_value($sformatf("%s upper r%0d c%0d", name, i, k),
					int'(ref_pix[0][i][k]), int'(a));
				check_value($sformatf("%s lower r%0d c%0d", name, i, k),
					int'(ref_pix[1][i][k]), int'(b));
			end
		end
	endtask

	task automatic test_reset();
		repeat (3) begin
			@(negedge clk);
			check_value("reset display_oe", 1, int'(display_oe));
			check_value("reset latch", 0, int'(latch));
			check_value("reset display_clk", 0, int'(display_clk));
			check_value("reset row_addr", 0, int'(row_addr));
		end
		rst = 1'b0;
		@(negedge clk); // first cycle out of reset
		check_value("after reset display_oe", 1, int'(display_oe));
		check_value("after reset latch", 0, int'(latch));
		check_value("after reset display_clk", 0, int'(display_clk));
		check_value("after reset row_addr", 0, int'(row_addr));
	endtask

	task automatic test_column_shift();
		int pulses;
		int since;
		pulses = 0;
		since  = 0;
		find_latch();
		while (latch)
			@(negedge clk);
		while (!latch) begin
			if (display_clk) begin
				if (pulses > 0)
					check_value("column_shift pulse spacing", 4, since);
				pulses++;
				since = 0;
			end
			since++;
			@(negedge clk);
		end
		check_value("column_shift pulses per row", columns, pulses);
	endtask

	task automatic test_row_timing();
		int r0;
		int n;
		find_latch();
		r0 = int'(row_addr);
		n  = 0;
		while (latch) begin
			n++;
			check_value("row_timing row during latch", r0, int'(row_addr));
			@(negedge clk);
		end
		check_value("row_timing latch cycles", latch_cycles, n);
		n = 0;
		while (!display_oe) begin
			n++;
			check_value("row_timing row while lit", r0, int'(row_addr));
			check_value("row_timing latch while lit", 0, int'(latch));
			@(negedge clk);
		end
		check_value("row_timing show cycles", show_cycles, n);
		n = 0;
		// blank phase, then fetch, data_wait, shift_setup of the next row
		while (!display_clk) begin
			check_value("row_timing latch idle", 0, int'(latch));
			check_value("row_timing display_oe idle", 1, int'(display_oe));
			check_value("row_timing row idle",
				(n < blank_cycles) ? r0 : (r0 + 1) % rows, int'(row_addr));
			n++;
			@(negedge clk);
		end
		check_value("row_timing idle cycles before shift", blank_cycles + 3, n);
	endtask

	task automatic test_row_sequence();
		panel_pkg::row_t   r;
		panel_pkg::pixel_t a;
		panel_pkg::pixel_t b;
		sync_frame_start();
		for (int i = 0; i < 2 * rows; i++) begin
			for (int k = 0; k < columns; k++) begin
				wait_shift(r, a, b);
				check_value("row_sequence row_addr", i % rows, int'(r));
			end
		end
	endtask

	task automatic test_pixel_data();
		for (int h = 0; h < 2; h++)
			for (int r = 0; r < rows; r++)
				for (int c = 0; c < columns; c++)
					write_pixel(h, r, c, panel_pkg::pixel_t'($urandom()));
		stop_writes();
		sync_frame_start();
		check_frame("pixel_data");
	endtask

	task automatic test_live_update();
		int r;
		int c;
		panel_pkg::pixel_t flip;
		repeat (int'($urandom() % row_cycles))
			@(negedge clk);
		for (int h = 0; h < 2; h++) begin
			r    = int'($urandom() % rows);
			c    = int'($urandom() % columns);
			flip = panel_pkg::pixel_t'(1 + $urandom() % 15); // nonzero, value always changes
			write_pixel(h, r, c, ref_pix[h][r][c] ^ flip);
		end
		stop_writes();
		sync_frame_start();
		check_frame("live_update");
	endtask

	initial begin
		rst       = 1'b1;
		fb_wr     = '0;
		fb_wr_stb = 1'b0;
		void'($urandom(32'h89d5));
		test_reset();
		test_column_shift();
		test_row_timing();
		test_row_sequence();
		test_pixel_data();
		test_live_update();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// twenty frames plus the buffer fill is far more than the tests need
	initial begin
		#(timeout_cycles * clk_period);
		$display("timeout: tests did not finish within %0d clock cycles", timeout_cycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/led_panel_top.sv
/* LED panel scan engine top */

`timescale 1ns/100ps
`default_nettype none

module led_panel_top #(
	parameter int columns      = panel_pkg::max_columns,
	parameter int rows         = panel_pkg::max_rows,
	parameter int latch_cycles = scan_pkg::def_latch_cycles,
	parameter int show_cycles  = scan_pkg::def_show_cycles,
	parameter int blank_cycles = scan_pkg::def_blank_cycles
) (
	input  wire                        clk,
	input  wire                        rst,
	input  wire panel_pkg::fb_write_t  fb_wr,
	input  wire                        fb_wr_stb,
	output wire panel_pkg::row_t       row_addr,
	output wire                        display_clk,
	output wire                        latch,
	output wire                        display_oe,
	output wire panel_pkg::pixel_t     dout_a, // upper half data
	output wire panel_pkg::pixel_t     dout_b  // lower half data
);

	wire panel_pkg::fb_read_t fb_rd;
	wire                      fb_rd_stb;

	frame_buffer frame_buffer_i (
		.clk       (clk),
		.rst       (rst),
		.fb_wr     (fb_wr),
		.fb_wr_stb (fb_wr_stb),
		.fb_rd     (fb_rd),
		.fb_rd_stb (fb_rd_stb),
		.pixel_a   (dout_a),
		.pixel_b   (dout_b)
	);

	scan_controller #(
		.columns      (columns),
		.rows         (rows),
		.latch_cycles (latch_cycles),
		.show_cycles  (show_cycles),
		.blank_cycles (blank_cycles)
	) scan_controller_i (
		.clk         (clk),
		.rst         (rst),
		.fb_rd       (fb_rd),
		.fb_rd_stb   (fb_rd_stb),
		.row_addr    (row_addr),
		.display_clk (display_clk),
		.latch       (latch),
		.display_oe  (display_oe)
	);

endmodule

`default_nettype wire

// File: design/scan_controller.sv
/* column and row scan FSM */

`timescale 1ns/100ps
`default_nettype none

module scan_controller #(
	parameter int columns      = panel_pkg::max_columns,
	parameter int rows         = panel_pkg::max_rows,
	parameter int latch_cycles = scan_pkg::def_latch_cycles,
	parameter int show_cycles  = scan_pkg::def_show_cycles,
	parameter int blank_cycles = scan_pkg::def_blank_cycles
) (
	input  wire                  clk,
	input  wire                  rst,
	output panel_pkg::fb_read_t  fb_rd,
	output logic                 fb_rd_stb,
	output panel_pkg::row_t      row_addr,
	output logic                 display_clk,
	output logic                 latch,
	output logic                 display_oe // active low
);

	// terminal counts
	localparam panel_pkg::col_t     last_col   = panel_pkg::col_t'(columns - 1);
	localparam panel_pkg::row_t     last_row   = panel_pkg::row_t'(rows - 1);
	localparam scan_pkg::phase_cnt_t latch_last = scan_pkg::phase_cnt_t'(latch_cycles - 1);
	localparam scan_pkg::phase_cnt_t show_last  = scan_pkg::phase_cnt_t'(show_cycles - 1);
	localparam scan_pkg::phase_cnt_t blank_last = scan_pkg::phase_cnt_t'(blank_cycles - 1);

	scan_pkg::scan_state_t state;
	panel_pkg::col_t       col;
	panel_pkg::row_t       row;
	scan_pkg::phase_cnt_t  phase; // shared by latch, show and blank

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= scan_pkg::fetch;
			col   <= '0;
			row   <= '0;
			phase <= '0;
		end else begin
			case (state)
				scan_pkg::fetch: begin
					state <= scan_pkg::data_wait;
				end
				scan_pkg::data_wait: begin
					state <= scan_pkg::shift_setup; // pixels arrive next cycle
				end
				scan_pkg::shift_setup: begin
					state <= scan_pkg::shift_clock;
				end
				scan_pkg::shift_clock: begin
					if (col == last_col) begin
						col   <= '0;
						phase <= '0;
						state <= scan_pkg::latch_row;
					end else begin
						col   <= col + 1'b1;
						state <= scan_pkg::fetch;
					end
				end
				scan_pkg::latch_row: begin
					if (phase == latch_last) begin
						phase <= '0;
						state <= scan_pkg::show_row;
					end else begin
						phase <= phase + 1'b1;
					end
				end
				scan_pkg::show_row: begin
					if (phase == show_last) begin
						phase <= '0;
						state <= scan_pkg::blank;
					end else begin
						phase <= phase + 1'b1;
					end
				end
				scan_pkg::blank: begin
					if (phase == blank_last) begin
						phase <= '0;
						state <= scan_pkg::fetch;
						// step row only once the panel is dark again
						if (row == last_row)
							row <= '0;
						else
							row <= row + 1'b1;
					end else begin
						phase <= phase + 1'b1;
					end
				end
				default: begin
					state <= scan_pkg::fetch;
				end
			endcase
		end
	end

	// controls straight from the registered state
	assign fb_rd.row   = row;
	assign fb_rd.col   = col;
	assign fb_rd_stb   = (state == scan_pkg::fetch);
	assign display_clk = (state == scan_pkg::shift_clock);
	assign latch       = (state == scan_pkg::latch_row);
	assign display_oe  = (state != scan_pkg::show_row);
	assign row_addr    = row;

	// a row step under latch or lit outputs would show the wrong row
	row_held_while_lit: assert property (@(posedge clk) disable iff (rst)
		!$stable(row_addr) |-> !latch && display_oe && $past(!latch && display_oe));

	row_in_range: assert property (@(posedge clk) disable iff (rst)
		int'(row_addr) < rows);

	// shift clock is a single-cycle pulse
	clk_single_pulse: assert property (@(posedge clk) disable iff (rst)
		display_clk |=> !display_clk);

endmodule

`default_nettype wire

// File: design/frame_buffer.sv
/* dual half frame buffer */

`timescale 1ns/100ps
`default_nettype none

module frame_buffer (
	input  wire                        clk,
	input  wire                        rst,
	input  wire panel_pkg::fb_write_t  fb_wr,
	input  wire                        fb_wr_stb,
	input  wire panel_pkg::fb_read_t   fb_rd,
	input  wire                        fb_rd_stb,
	output panel_pkg::pixel_t          pixel_a,
	output panel_pkg::pixel_t          pixel_b
);

	// one array per panel half
	panel_pkg::pixel_t mem_a [panel_pkg::max_rows][panel_pkg::max_columns];
	panel_pkg::pixel_t mem_b [panel_pkg::max_rows][panel_pkg::max_columns];

	panel_pkg::pixel_t rd_a; // first read stage
	panel_pkg::pixel_t rd_b;
	logic              rd_vld; // first stage holds a fresh read

	// write port, half selects the array
	always_ff @(posedge clk) begin
		if (fb_wr_stb) begin
			if (fb_wr.half)
				mem_b[fb_wr.row][fb_wr.col] <= fb_wr.pixel;
			else
				mem_a[fb_wr.row][fb_wr.col] <= fb_wr.pixel;
		end
	end

	// same position from both halves, old data on a colliding write
	always_ff @(posedge clk) begin
		if (fb_rd_stb) begin
			rd_a <= mem_a[fb_rd.row][fb_rd.col];
			rd_b <= mem_b[fb_rd.row][fb_rd.col];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_vld  <= 1'b0;
			pixel_a <= '0;
			pixel_b <= '0;
		end else begin
			rd_vld <= fb_rd_stb;
			if (rd_vld) begin // second stage, outputs hold until next read
				pixel_a <= rd_a;
				pixel_b <= rd_b;
			end
		end
	end

	// one request per column, the pipeline takes no back-to-back reads
	rd_stb_spaced: assert property (@(posedge clk) disable iff (rst)
		fb_rd_stb |=> !fb_rd_stb);

endmodule

`default_nettype wire

// File: design/scan_pkg.sv
/* scan timing definitions */

`default_nettype none

package scan_pkg;

	// per column: fetch, data_wait, shift_setup, shift_clock
	// per row: latch_row, show_row, blank
	typedef enum logic [2:0] {
		fetch,
		data_wait,
		shift_setup,
		shift_clock,
		latch_row,
		show_row,
		blank
	} scan_state_t;

	typedef logic [15:0] phase_cnt_t; // latch/show/blank duration counter

	localparam int def_latch_cycles = 6;
	localparam int def_show_cycles  = 6;
	localparam int def_blank_cycles = 5;

endpackage

`default_nettype wire

// File: design/panel_pkg.sv
/* panel geometry and frame buffer types */

`default_nettype none

package panel_pkg;

	// largest panel the frame buffer is sized for
	localparam int max_columns = 64;
	localparam int max_rows    = 32; // rows per half

	typedef logic [5:0] col_t;   // column index
	typedef logic [4:0] row_t;   // row index within one half
	typedef logic [3:0] pixel_t; // colour bits as shifted into the panel

	// write request from the external loader
	typedef struct packed {
		logic   half; // 0 upper, 1 lower
		row_t   row;
		col_t   col;
		pixel_t pixel;
	} fb_write_t;

	// read request, one position in both halves
	typedef struct packed {
		row_t row;
		col_t col;
	} fb_read_t;

endpackage

`default_nettype wire
